// ==== arbiter.sv ====
////////////////////////////////////////
// Y then X routing, round-robin per output
// Grants need a head flit and a credit
////////////////////////////////////////
`default_nettype none

module arbiter
  import noc_router_pkg::*;
(
  input  wire logic                          clk,
  input  wire logic                          reset_i,
  input  wire logic  [COORD_W-1:0]           router_y_i,
  input  wire logic  [COORD_W-1:0]           router_x_i,
  input  wire flit_u [NUM_PORTS-1:0]         head_i,
  input  wire logic  [NUM_PORTS-1:0]         empty_i,
  input  wire logic  [NUM_PORTS-1:0]         has_credit_i,
  output logic       [NUM_PORTS-1:0]         read_o,
  output logic       [NUM_PORTS-1:0]         credit_use_o,
  output logic       [NUM_PORTS-1:0]         grant_o,
  output logic       [NUM_PORTS-1:0][1:0]    grant_src_o
);

  // Requests indexed by output, then input
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req;
  logic [NUM_PORTS-1:0][1:0]           rr_ptr;

  function automatic logic [1:0] route_of(input flit_u f,
                                          input logic [COORD_W-1:0] my_y,
                                          input logic [COORD_W-1:0] my_x);
    if (f.hdr.dest_y != my_y) begin
      return 2'(PORT_S);
    end else if (f.hdr.dest_x != my_x) begin
      return 2'(PORT_W);
    end
    return 2'(PORT_L);
  endfunction

  always_comb begin
    req = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (!empty_i[i]) begin
        req[route_of(head_i[i], router_y_i, router_x_i)][i] = 1'b1;
      end
    end
  end

  // First requester at or after the pointer wins
  always_comb begin
    int cand;
    grant_o     = '0;
    grant_src_o = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int k = 0; k < NUM_PORTS; k++) begin
        cand = int'(rr_ptr[o]) + k;
        if (cand >= NUM_PORTS) begin
          cand = cand - NUM_PORTS;
        end
        if (has_credit_i[o] && !grant_o[o] && req[o][cand]) begin
          grant_o[o]     = 1'b1;
          grant_src_o[o] = 2'(cand);
        end
      end
    end
  end

  // Each input requests one output, so at most one read per input
  always_comb begin
    read_o = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (grant_o[o] && grant_src_o[o] == 2'(i)) begin
          read_o[i] = 1'b1;
        end
      end
    end
  end

  assign credit_use_o = grant_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        rr_ptr[o] <= 2'(PORT_S);
      end
    end else begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (grant_o[o]) begin
          rr_ptr[o] <= (grant_src_o[o] == 2'(NUM_PORTS - 1)) ? '0 : grant_src_o[o] + 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== credit_counter.sv ====
////////////////////////////////////////
// CREDITS equals the downstream buffer depth
////////////////////////////////////////
`default_nettype none

module credit_counter #(
  parameter int CREDITS = 4
) (
  input  wire logic clk,
  input  wire logic reset_i,
  input  wire logic inc_i,
  input  wire logic dec_i,
  output logic      has_credit_o
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] count;

  // Return and use in one cycle cancel out
  always_ff @(posedge clk) begin
    if (reset_i) begin
      count <= CNT_W'(CREDITS);
    end else if (inc_i && !dec_i && count != CNT_W'(CREDITS)) begin
      count <= count + 1'b1;
    end else if (dec_i && !inc_i && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign has_credit_o = (count != '0);

endmodule

`default_nettype wire

// ==== crossbar_switch.sv ====
////////////////////////////////////////
// Output register stage, one cycle latency
////////////////////////////////////////
`default_nettype none

module crossbar_switch
  import noc_router_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       reset_i,
  input  wire flit_u [NUM_PORTS-1:0]      head_i,
  input  wire logic  [NUM_PORTS-1:0]      grant_i,
  input  wire logic  [NUM_PORTS-1:0][1:0] grant_src_i,
  output flit_u      [NUM_PORTS-1:0]      data_o,
  output logic       [NUM_PORTS-1:0]      valid_o
);

  logic [NUM_PORTS-1:0][15:0] sel_raw;

  // Source mux per output
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      case (grant_src_i[o])
        2'(PORT_W): sel_raw[o] = head_i[PORT_W].raw;
        2'(PORT_L): sel_raw[o] = head_i[PORT_L].raw;
        default:    sel_raw[o] = head_i[PORT_S].raw;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (grant_i[o]) begin
        data_o[o].raw <= sel_raw[o];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= '0;
    end else begin
      valid_o <= grant_i;
    end
  end

endmodule

`default_nettype wire

// ==== input_buffer.sv ====
////////////////////////////////////////
// BUF_DEPTH must be a power of two, >= 2
// Writes into a full buffer are dropped
////////////////////////////////////////
`default_nettype none

module input_buffer #(
  parameter int BUF_DEPTH = 4
) (
  input  wire logic        clk,
  input  wire logic        reset_i,
  input  wire logic [15:0] data_i,
  input  wire logic        write_i,
  input  wire logic        read_i,
  output logic      [15:0] data_o,
  output logic             empty_o
);

  localparam int PTR_W = $clog2(BUF_DEPTH);
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  logic [15:0]      mem [BUF_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_write;
  logic             do_read;

  assign full     = (count == CNT_W'(BUF_DEPTH));
  assign empty_o  = (count == '0);
  assign do_write = write_i && !full;
  assign do_read  = read_i && !empty_o;

  // Head flit is visible without a read
  assign data_o = mem[rd_ptr];

  // Pointers wrap on their own
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_write) - CNT_W'(do_read);
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== ne_corner_router.f ====
noc_router_pkg.sv
input_buffer.sv
credit_counter.sv
arbiter.sv
crossbar_switch.sv
ne_corner_router.sv
ne_corner_router_props.sv
ne_corner_router_tb.sv

// ==== ne_corner_router.sv ====
////////////////////////////////////////
// Corner router, S, W and L ports only
// Upstream keeps within BUF_DEPTH credits
////////////////////////////////////////
`default_nettype none

module ne_corner_router
  import noc_router_pkg::*;
#(
  parameter int BUF_DEPTH = 4,
  parameter int CREDITS   = 4
) (
  input  wire logic               clk,
  input  wire logic               reset_i,
  input  wire logic [COORD_W-1:0] router_y_i,
  input  wire logic [COORD_W-1:0] router_x_i,
  input  wire logic [15:0]        s_data_i,
  input  wire logic [15:0]        w_data_i,
  input  wire logic [15:0]        l_data_i,
  input  wire logic               s_valid_i,
  input  wire logic               w_valid_i,
  input  wire logic               l_valid_i,
  input  wire logic               s_credit_i,
  input  wire logic               w_credit_i,
  input  wire logic               l_credit_i,
  output logic      [15:0]        s_data_o,
  output logic      [15:0]        w_data_o,
  output logic      [15:0]        l_data_o,
  output logic                    s_valid_o,
  output logic                    w_valid_o,
  output logic                    l_valid_o,
  output logic                    s_credit_o,
  output logic                    w_credit_o,
  output logic                    l_credit_o
);

  logic  [NUM_PORTS-1:0][15:0] in_data;
  logic  [NUM_PORTS-1:0]       in_valid;
  logic  [NUM_PORTS-1:0]       credit_ret;
  flit_u [NUM_PORTS-1:0]       head;
  logic  [NUM_PORTS-1:0]       empty;
  logic  [NUM_PORTS-1:0]       read;
  logic  [NUM_PORTS-1:0]       credit_use;
  logic  [NUM_PORTS-1:0]       has_credit;
  logic  [NUM_PORTS-1:0]       grant;
  logic  [NUM_PORTS-1:0][1:0]  grant_src;
  flit_u [NUM_PORTS-1:0]       out_data;
  logic  [NUM_PORTS-1:0]       out_valid;

  assign in_data    = {l_data_i, w_data_i, s_data_i};
  assign in_valid   = {l_valid_i, w_valid_i, s_valid_i};
  assign credit_ret = {l_credit_i, w_credit_i, s_credit_i};

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    input_buffer #(.BUF_DEPTH(BUF_DEPTH)) ib (
      .clk     (clk),
      .reset_i (reset_i),
      .data_i  (in_data[p]),
      .write_i (in_valid[p]),
      .read_i  (read[p]),
      .data_o  (head[p].raw),
      .empty_o (empty[p])
    );

    credit_counter #(.CREDITS(CREDITS)) cc (
      .clk          (clk),
      .reset_i      (reset_i),
      .inc_i        (credit_ret[p]),
      .dec_i        (credit_use[p]),
      .has_credit_o (has_credit[p])
    );
  end

  arbiter arb (
    .clk          (clk),
    .reset_i      (reset_i),
    .router_y_i   (router_y_i),
    .router_x_i   (router_x_i),
    .head_i       (head),
    .empty_i      (empty),
    .has_credit_i (has_credit),
    .read_o       (read),
    .credit_use_o (credit_use),
    .grant_o      (grant),
    .grant_src_o  (grant_src)
  );

  crossbar_switch xbar (
    .clk         (clk),
    .reset_i     (reset_i),
    .head_i      (head),
    .grant_i     (grant),
    .grant_src_i (grant_src),
    .data_o      (out_data),
    .valid_o     (out_valid)
  );

  assign s_data_o = out_data[PORT_S].raw;
  assign w_data_o = out_data[PORT_W].raw;
  assign l_data_o = out_data[PORT_L].raw;

  assign s_valid_o = out_valid[PORT_S];
  assign w_valid_o = out_valid[PORT_W];
  assign l_valid_o = out_valid[PORT_L];

  // Every buffer read frees one upstream slot
  assign s_credit_o = read[PORT_S];
  assign w_credit_o = read[PORT_W];
  assign l_credit_o = read[PORT_L];

endmodule

`default_nettype wire

// ==== ne_corner_router_props.sv ====
////////////////////////////////////////
// Bound to ne_corner_router, mesh y/x fixed per run
////////////////////////////////////////
`default_nettype none

module ne_corner_router_props #(
  parameter int CREDITS = 4
) (
  input wire logic        clk,
  input wire logic        reset_i,
  input wire logic [3:0]  router_y_i,
  input wire logic [3:0]  router_x_i,
  input wire logic [15:0] s_data_o,
  input wire logic [15:0] w_data_o,
  input wire logic [15:0] l_data_o,
  input wire logic        s_valid_o,
  input wire logic        w_valid_o,
  input wire logic        l_valid_o,
  input wire logic        s_credit_o,
  input wire logic        w_credit_o,
  input wire logic        l_credit_o,
  input wire logic        s_credit_i,
  input wire logic        w_credit_i,
  input wire logic        l_credit_i
);

  logic [2:0] vld;
  logic [2:0] ret;
  int         sent [3];

  assign vld = {l_valid_o, w_valid_o, s_valid_o};
  assign ret = {l_credit_i, w_credit_i, s_credit_i};

  // Flits in flight per output, not yet credited back
  always @(posedge clk) begin
    for (int o = 0; o < 3; o++) begin
      if (reset_i) begin
        sent[o] <= 0;
      end else begin
        sent[o] <= sent[o] + int'(vld[o]) - int'(ret[o]);
      end
    end
  end

  a_quiet_in_reset: assert property (@(posedge clk)
    reset_i && $past(reset_i) |-> vld == 3'b0 && {l_credit_o, w_credit_o, s_credit_o} == 3'b0)
    else $error("valid or credit output high during reset");

  a_s_route: assert property (@(posedge clk) disable iff (reset_i)
    s_valid_o |-> s_data_o[15:12] != router_y_i)
    else $error("flit on south output does not route south");

  a_w_route: assert property (@(posedge clk) disable iff (reset_i)
    w_valid_o |-> w_data_o[15:12] == router_y_i && w_data_o[11:8] != router_x_i)
    else $error("flit on west output does not route west");

  a_l_route: assert property (@(posedge clk) disable iff (reset_i)
    l_valid_o |-> l_data_o[15:12] == router_y_i && l_data_o[11:8] == router_x_i)
    else $error("flit on local output does not route local");

  a_credit_bound: assert property (@(posedge clk) disable iff (reset_i)
    sent[0] <= CREDITS && sent[1] <= CREDITS && sent[2] <= CREDITS)
    else $error("output has more flits outstanding than credits");

endmodule

bind ne_corner_router ne_corner_router_props #(.CREDITS(CREDITS)) props0 (.*);

`default_nettype wire

// ==== ne_corner_router_tb.sv ====
////////////////////////////////////////
// Router at y 3, x 3; payload tag high nibble = source port
////////////////////////////////////////
`default_nettype none

module ne_corner_router_tb
  import noc_router_pkg::*;
;
  localparam int BUF_DEPTH = 4;
  localparam int CREDITS   = 4;

  logic             clk;
  logic             reset_i;
  logic [3:0]       router_y_i;
  logic [3:0]       router_x_i;
  logic [2:0][15:0] data_in;
  logic [2:0]       valid_in;
  logic [2:0]       credit_in;
  logic [15:0]      data_out [3];
  logic [2:0]       valid_out;
  logic [2:0]       credit_out;

  logic [15:0] send_q [3][$];
  logic [15:0] sb_q [9][$];
  int          up_cred [3];
  int          written [3];
  int          returned [3];
  int          outstanding [3];
  logic [2:0]  hold;
  int          rr_l;
  bit          fair_chk;
  string       out_name [3] = '{"s_data_o", "w_data_o", "l_data_o"};

  ne_corner_router #(.BUF_DEPTH(BUF_DEPTH), .CREDITS(CREDITS)) dut0 (
    .clk(clk), .reset_i(reset_i), .router_y_i(router_y_i), .router_x_i(router_x_i),
    .s_data_i(data_in[0]), .w_data_i(data_in[1]), .l_data_i(data_in[2]),
    .s_valid_i(valid_in[0]), .w_valid_i(valid_in[1]), .l_valid_i(valid_in[2]),
    .s_credit_i(credit_in[0]), .w_credit_i(credit_in[1]), .l_credit_i(credit_in[2]),
    .s_data_o(data_out[0]), .w_data_o(data_out[1]), .l_data_o(data_out[2]),
    .s_valid_o(valid_out[0]), .w_valid_o(valid_out[1]), .l_valid_o(valid_out[2]),
    .s_credit_o(credit_out[0]), .w_credit_o(credit_out[1]), .l_credit_o(credit_out[2])
  );

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    end
  endtask

  // Y first, then X, for the router at (3, 3)
  function automatic int route_to(logic [15:0] f);
    if (f[15:12] != 4'd3) begin
      return PORT_S;
    end else if (f[11:8] != 4'd3) begin
      return PORT_W;
    end
    return PORT_L;
  endfunction

  function automatic bit drained();
    int n;
    n = 0;
    for (int i = 0; i < 3; i++) begin
      n = n + send_q[i].size() + outstanding[i];
    end
    for (int k = 0; k < 9; k++) begin
      n = n + sb_q[k].size();
    end
    return n == 0;
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Monitor outputs, then drive upstream and downstream models
  initial begin
    int src;
    int exp_src;
    int c;
    logic [15:0] f;
    void'($urandom(68943));
    forever begin
      @(negedge clk);
      if (!reset_i) begin
        for (int o = 0; o < 3; o++) begin
          if (valid_out[o]) begin
            src = int'(data_out[o][7:4]);
            if (src > 2) begin
              abort_run("flit with an unknown source tag left the router");
            end
            if (o == PORT_L) begin
              if (fair_chk) begin
                exp_src = -1;
                for (int k = 0; k < 3; k++) begin
                  c = (rr_l + k) % 3;
                  if (exp_src < 0 && sb_q[c * 3 + PORT_L].size() > 0) begin
                    exp_src = c;
                  end
                end
                check_value("l_data_o source", 32'(src), 32'(exp_src));
              end
              rr_l = (src + 1) % 3;
            end
            if (sb_q[src * 3 + o].size() == 0) begin
              abort_run($sformatf("unexpected flit %h on %s", data_out[o], out_name[o]));
            end
            f = sb_q[src * 3 + o].pop_front();
            check_value(out_name[o], 32'(data_out[o]), 32'(f));
            outstanding[o]++;
            check_value("outstanding over credits", 32'(outstanding[o] > CREDITS), 32'(0));
          end
        end
        for (int o = 0; o < 3; o++) begin
          credit_in[o] = 1'b0;
          if (!hold[o] && outstanding[o] > 0 && $urandom % 3 == 0) begin
            credit_in[o] = 1'b1;
            outstanding[o]--;
          end
        end
        for (int i = 0; i < 3; i++) begin
          valid_in[i] = 1'b0;
          if (send_q[i].size() > 0 && up_cred[i] > 0 && $urandom % 4 != 0) begin
            data_in[i] = send_q[i].pop_front();
            valid_in[i] = 1'b1;
            up_cred[i]--;
            written[i]++;
            sb_q[i * 3 + route_to(data_in[i])].push_back(data_in[i]);
          end
        end
        // Credit seen now frees a slot only after the next edge
        for (int i = 0; i < 3; i++) begin
          if (credit_out[i]) begin
            up_cred[i]++;
            returned[i]++;
          end
        end
      end
    end
  end

  initial begin
    int fd;
    int ph;
    int port;
    int dy;
    int dx;
    int tag;
    string line;
    logic [15:0] ph_flit [$];
    int ph_port [$];
    int ph_phase [$];
    reset_i = 1'b1;
    router_y_i = 4'd3;
    router_x_i = 4'd3;
    data_in = '0;
    valid_in = '0;
    credit_in = '0;
    hold = '0;
    rr_l = PORT_S;
    fair_chk = 1'b0;
    for (int i = 0; i < 3; i++) begin
      up_cred[i] = BUF_DEPTH;
      written[i] = 0;
      returned[i] = 0;
      outstanding[i] = 0;
    end
    fd = $fopen("ne_corner_router_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open ne_corner_router_tests.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 4 && line[0] != "#" &&
          $sscanf(line, "%d %d %h %h %h", ph, port, dy, dx, tag) == 5) begin
        ph_phase.push_back(ph);
        ph_port.push_back(port);
        ph_flit.push_back({4'(dy), 4'(dx), 8'(tag)});
      end
    end
    $fclose(fd);
    fork
      begin
        #((ph_flit.size() * 200 + 20) * 8);
        abort_run("timeout, flits did not drain in time");
      end
    join_none
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    // Phase 0 free flow, 1 all credits held, 2 local output contention
    for (int p = 0; p < 3; p++) begin
      hold = (p == 1) ? 3'b111 : (p == 2) ? 3'b100 : 3'b000;
      for (int k = 0; k < ph_flit.size(); k++) begin
        if (ph_phase[k] == p) begin
          send_q[ph_port[k]].push_back(ph_flit[k]);
        end
      end
      if (p > 0) begin
        while (send_q[0].size() + send_q[1].size() + send_q[2].size() > 0) begin
          @(negedge clk);
        end
        repeat (30) @(negedge clk);
        fair_chk = (p == 2);
        hold = 3'b000;
      end
      while (!drained()) begin
        @(negedge clk);
      end
      fair_chk = 1'b0;
    end
    repeat (20) @(negedge clk);
    for (int i = 0; i < 3; i++) begin
      check_value("credit_o count", 32'(returned[i]), 32'(written[i]));
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ne_corner_router_tests.txt ====
# phase port dest_y dest_x tag, port 0=S 1=W 2=L, last three in hex
# phase 0 free flow, 1 credits withheld, 2 S and W contend for local output
0 0 3 3 01
0 0 3 1 02
0 1 2 3 11
0 1 3 3 12
0 2 1 0 21
0 2 3 2 22
0 2 3 3 23
1 1 0 3 13
1 1 1 3 14
1 1 2 5 15
1 2 0 0 24
1 2 5 3 25
1 2 7 7 26
1 0 3 0 03
2 2 3 3 27
2 2 3 3 28
2 0 3 3 04
2 0 3 3 05
2 0 3 3 06
2 1 3 3 16
2 1 3 3 17
2 1 3 3 18

// ==== noc_router_pkg.sv ====
////////////////////////////////////////
// Three port corner router, 16-bit flits
// Port indices are shared by inputs and outputs
////////////////////////////////////////
`default_nettype none

package noc_router_pkg;

  localparam int NUM_PORTS = 3;

  localparam int PORT_S = 0;
  localparam int PORT_W = 1;
  localparam int PORT_L = 2;

  // One mesh coordinate
  localparam int COORD_W = 4;

  // Header view for routing, raw view for storage and transport
  typedef union packed {
    struct packed {
      logic [COORD_W-1:0] dest_y;
      logic [COORD_W-1:0] dest_x;
      logic [7:0]         payload;
    } hdr;
    logic [15:0] raw;
  } flit_u;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, pass only if the pass message is printed
verilator --binary -f ne_corner_router.f --top ne_corner_router_tb -o tb_sim --Mdir obj_dir \
  && ./obj_dir/tb_sim | grep "Testbench passed" \
  || { echo "simulation did not pass"; exit 1; }
